/* verilog/core.sv */
// Core type and encoding package
`default_nettype none

package core;

    // basic data types.
    typedef logic [31:0] word_t;  // data, address and instruction word.
    typedef logic [4:0]  addr_t;  // register file index.

    // major opcodes of the supported instruction subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // register-register alu operation.
        OPC_OP_IMM = 7'b0010011,  // register-immediate alu operation.
        OPC_LOAD   = 7'b0000011,  // word load.
        OPC_STORE  = 7'b0100011,  // word store.
        OPC_BRANCH = 7'b1100011,  // conditional branch.
        OPC_JAL    = 7'b1101111,  // jump and link.
        OPC_LUI    = 7'b0110111   // load upper immediate.
    } opcode_e;

    // operations the alu can perform.
    typedef enum logic [2:0] {
        ALU_ADD,  // addition, also used for effective addresses.
        ALU_SUB,  // subtraction.
        ALU_AND,  // bitwise and.
        ALU_OR,   // bitwise or.
        ALU_XOR,  // bitwise exclusive or.
        ALU_SLT,  // signed set-less-than.
        ALU_SLL,  // logical shift left.
        ALU_SRL   // logical shift right.
    } alu_op_e;

    // what the memory stage has to do with its instruction.
    typedef enum logic [1:0] {
        MEM_NONE,  // result goes straight to the write port.
        MEM_LOAD,  // read a word from the bus.
        MEM_STORE  // write a word to the bus.
    } mem_op_e;

    // funct3 values of the alu instructions.
    localparam logic [2:0] F3_ADD = 3'b000;  // add and sub share this code.
    localparam logic [2:0] F3_SLL = 3'b001;  // shift left.
    localparam logic [2:0] F3_SLT = 3'b010;  // signed compare.
    localparam logic [2:0] F3_XOR = 3'b100;  // exclusive or.
    localparam logic [2:0] F3_SRL = 3'b101;  // shift right logical.
    localparam logic [2:0] F3_OR  = 3'b110;  // or.
    localparam logic [2:0] F3_AND = 3'b111;  // and.

    // funct3 values of the branches.
    localparam logic [2:0] F3_BEQ = 3'b000;  // branch if equal.
    localparam logic [2:0] F3_BNE = 3'b001;  // branch if not equal.

    // funct7 value that turns add into sub.
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // byte distance between consecutive instructions.
    localparam logic [31:0] INST_BYTES = 32'd4;

endpackage

`default_nettype wire

/* verilog/fetch.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter core::word_t RESET_ADDR = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  core::word_t redirect_target,
    input  logic        inst_take,
    input  logic        fetch_gnt,
    input  logic        fetch_valid,
    input  core::word_t fetch_rdata,
    output logic        fetch_req,
    output core::word_t fetch_addr,
    output logic        inst_valid,
    output core::word_t inst,
    output core::word_t inst_pc
);
    import core::*;

    logic  running;    // low for the first cycle after reset so no request leaks out.
    word_t pc;         // address of the next instruction to request.
    logic  buf_valid;  // the one-entry buffer holds an instruction.
    word_t buf_inst;
    word_t buf_pc;
    logic  pend;       // a read is in flight and still wanted.
    word_t pend_addr;  // address of that read.
    logic  resp;       // the wanted read returns this cycle.
    logic  granted;    // a request leaves this cycle.

    assign resp       = pend && fetch_valid;                      // stale data is ignored.
    assign inst_valid = buf_valid || resp;                        // fresh data is shown at once.
    assign inst       = buf_valid ? buf_inst : fetch_rdata;
    assign inst_pc    = buf_valid ? buf_pc : pend_addr;
    assign fetch_addr = pc;
    assign granted    = fetch_req && fetch_gnt;

    // ask again only when the slot frees up and nothing is still on its way back.
    assign fetch_req = running && (!inst_valid || inst_take) && (!pend || fetch_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running   <= 1'b0;
            pc        <= RESET_ADDR;  // first request goes to the reset address.
            pend      <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                pc        <= redirect_target;  // a taken branch or jal wins over the increment.
                pend      <= 1'b0;             // any read already issued is dropped.
                buf_valid <= 1'b0;
            end else begin
                if (granted) pc <= pc + INST_BYTES;
                if (granted) pend <= 1'b1;
                else if (fetch_valid) pend <= 1'b0;
                if (resp && !inst_take) buf_valid <= 1'b1;  // park what execute did not take.
                else if (inst_take) buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (granted) pend_addr <= pc;  // remember where the outstanding read came from.
        if (resp && !inst_take) begin
            buf_inst <= fetch_rdata;
            buf_pc   <= pend_addr;
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic        clk,
    input  core::addr_t rs1_addr,
    input  core::addr_t rs2_addr,
    output core::word_t rs1_data,
    output core::word_t rs2_data,
    input  logic        wb_en,
    input  core::addr_t wb_addr,
    input  core::word_t wb_data
);
    import core::*;

    word_t regs [32];  // x0 is never written and reads as zero below.

    // reads are combinational so execute sees the operands in the same cycle.
    always_comb begin
        if (rs1_addr == '0) rs1_data = '0;
        else rs1_data = regs[rs1_addr];
        if (rs2_addr == '0) rs2_data = '0;
        else rs2_data = regs[rs2_addr];
    end

    // a write lands at the end of the cycle it is presented in.
    always_ff @(posedge clk) begin
        if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;  // writes to x0 are dropped.
        end
    end

endmodule

`default_nettype wire

/* verilog/execute.sv */
// Decode and execute stage
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          inst_valid,
    input  core::word_t   inst,
    input  core::word_t   inst_pc,
    output logic          inst_take,
    output core::addr_t   rs1_addr,
    output core::addr_t   rs2_addr,
    input  core::word_t   rs1_data,
    input  core::word_t   rs2_data,
    input  logic          wb_en,
    input  core::addr_t   wb_addr,
    input  core::word_t   wb_data,
    input  logic          m_ready,
    output logic          m_valid,
    output core::mem_op_e m_op,
    output logic          m_rd_en,
    output core::addr_t   m_rd,
    output core::word_t   m_result,
    output core::word_t   m_store_data,
    output logic          redirect,
    output core::word_t   redirect_target
);
    import core::*;

    opcode_e    opcode;
    alu_op_e    f3_op;   // alu operation selected by funct3 alone.
    alu_op_e    alu_op;
    mem_op_e    mem_op;
    addr_t      rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      op_a, op_b, alu_b, alu_result, result;
    logic       rd_en, is_jal, branch_taken;

    // instruction fields.
    assign opcode   = opcode_e'(inst[6:0]);
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // sign-extended immediates of each format.
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // the write port is newer than the register file, including a load finishing now.
    assign op_a = (wb_en && wb_addr == rs1_addr && rs1_addr != '0) ? wb_data : rs1_data;
    assign op_b = (wb_en && wb_addr == rs2_addr && rs2_addr != '0) ? wb_data : rs2_data;

    always_comb begin
        case (funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLL:  f3_op = ALU_SLL;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_SRL:  f3_op = ALU_SRL;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;  // unsigned compare is not part of the subset.
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // loads and stores only need an address sum.
        mem_op = MEM_NONE;
        rd_en  = 1'b0;
        alu_b  = imm_i;
        case (opcode)
            OPC_OP: begin
                rd_en  = 1'b1;
                alu_b  = op_b;
                alu_op = (funct3 == F3_ADD && funct7 == F7_SUB) ? ALU_SUB : f3_op;
            end
            OPC_OP_IMM: begin
                rd_en  = 1'b1;
                alu_op = f3_op;  // shift amount sits in the low immediate bits.
            end
            OPC_LOAD: begin
                rd_en  = 1'b1;
                mem_op = MEM_LOAD;
            end
            OPC_STORE: begin
                mem_op = MEM_STORE;
                alu_b  = imm_s;
            end
            OPC_LUI, OPC_JAL: rd_en = 1'b1;
            default: ;  // branches and unknown words write nothing.
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + alu_b;
            ALU_SUB: alu_result = op_a - alu_b;
            ALU_AND: alu_result = op_a & alu_b;
            ALU_OR:  alu_result = op_a | alu_b;
            ALU_XOR: alu_result = op_a ^ alu_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_SLL: alu_result = op_a << alu_b[4:0];
            ALU_SRL: alu_result = op_a >> alu_b[4:0];
        endcase
    end

    // control flow is resolved here, so only the jump itself is ever consumed before the flush.
    assign is_jal       = opcode == OPC_JAL;
    assign branch_taken = opcode == OPC_BRANCH &&
                          ((funct3 == F3_BEQ && op_a == op_b) ||
                           (funct3 == F3_BNE && op_a != op_b));

    assign inst_take       = inst_valid && m_ready;  // consume and issue in one cycle.
    assign redirect        = inst_take && (is_jal || branch_taken);
    assign redirect_target = inst_pc + (is_jal ? imm_j : imm_b);

    // link value for jal, upper immediate for lui, alu output for the rest.
    assign result = is_jal ? inst_pc + INST_BYTES : (opcode == OPC_LUI ? imm_u : alu_result);

    always_ff @(posedge clk) begin
        if (!rst_n) m_valid <= 1'b0;
        else m_valid <= inst_take;  // one strobe per issued instruction.
    end

    always_ff @(posedge clk) begin
        if (inst_take) begin
            m_op         <= mem_op;
            m_rd_en      <= rd_en;
            m_rd         <= rd;
            m_result     <= result;
            m_store_data <= op_b;
        end
    end

endmodule

`default_nettype wire

/* verilog/memory.sv */
// Memory access and writeback stage
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          m_valid,
    input  core::mem_op_e m_op,
    input  logic          m_rd_en,
    input  core::addr_t   m_rd,
    input  core::word_t   m_result,
    input  core::word_t   m_store_data,
    output logic          m_ready,
    output logic          mem_stage_req,
    output logic          mem_stage_we,
    output core::word_t   mem_stage_addr,
    output core::word_t   mem_stage_wdata,
    input  logic          load_valid,
    input  core::word_t   load_rdata,
    output logic          wb_en,
    output core::addr_t   wb_addr,
    output core::word_t   wb_data
);
    import core::*;

    logic  ld_wait;   // load data comes back this cycle.
    logic  ld_rd_en;
    addr_t ld_rd;

    // the bus has priority for this stage, so the request goes out the cycle after issue.
    assign mem_stage_req   = m_valid && m_op != MEM_NONE;
    assign mem_stage_we    = m_valid && m_op == MEM_STORE;
    assign mem_stage_addr  = m_result;
    assign mem_stage_wdata = m_store_data;
    assign m_ready         = !(m_valid && m_op == MEM_LOAD);  // hold execute off one cycle.

    always_comb begin
        if (ld_wait) begin
            wb_en   = load_valid && ld_rd_en && ld_rd != '0;
            wb_addr = ld_rd;
            wb_data = load_rdata;
        end else begin
            wb_en   = m_valid && m_op == MEM_NONE && m_rd_en && m_rd != '0;
            wb_addr = m_rd;
            wb_data = m_result;  // alu, lui or link value.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_wait <= 1'b0;
        end else begin
            ld_wait <= m_valid && m_op == MEM_LOAD;
        end
    end

    always_ff @(posedge clk) begin
        if (m_valid && m_op == MEM_LOAD) begin
            ld_rd_en <= m_rd_en;  // destination of the load that is in flight.
            ld_rd    <= m_rd;
        end
    end

endmodule

`default_nettype wire

/* verilog/arbitrate.sv */
// Shared memory bus arbiter
`timescale 1ns/1ps
`default_nettype none

module arbitrate (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_stage_req,
    input  logic        mem_stage_we,
    input  core::word_t mem_stage_addr,
    input  core::word_t mem_stage_wdata,
    input  logic        fetch_req,
    input  core::word_t fetch_addr,
    output logic        fetch_gnt,
    output logic        fetch_valid,
    output logic        load_valid,
    output core::word_t fetch_rdata,
    output core::word_t load_rdata,
    output logic        mem_req,
    output logic        mem_we,
    output core::word_t mem_addr,
    output core::word_t mem_wdata,
    input  core::word_t mem_rdata
);

    // which requester the read of last cycle belongs to.
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_LOAD
    } owner_e;

    owner_e owner;

    assign fetch_gnt = fetch_req && !mem_stage_req;  // the memory stage always wins.
    assign mem_req   = mem_stage_req || fetch_req;
    assign mem_we    = mem_stage_req && mem_stage_we;  // fetch never writes.
    assign mem_addr  = mem_stage_req ? mem_stage_addr : fetch_addr;
    assign mem_wdata = mem_stage_wdata;

    // read data arrives one cycle after the request and is steered by the owner.
    assign fetch_valid = owner == OWN_FETCH;
    assign load_valid  = owner == OWN_LOAD;
    assign fetch_rdata = mem_rdata;
    assign load_rdata  = mem_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) owner <= OWN_NONE;
        else if (mem_stage_req && !mem_stage_we) owner <= OWN_LOAD;
        else if (fetch_gnt) owner <= OWN_FETCH;
        else owner <= OWN_NONE;  // stores and idle cycles return nothing.
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
// Three-stage core top level
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter core::word_t RESET_ADDR = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        mem_req,
    output logic        mem_we,
    output core::word_t mem_addr,
    output core::word_t mem_wdata,
    input  core::word_t mem_rdata
);
    import core::*;

    // fetch to execute.
    logic    inst_valid, inst_take, redirect;
    word_t   inst, inst_pc, redirect_target;

    // fetch side of the bus.
    logic    fetch_req, fetch_gnt, fetch_valid;
    word_t   fetch_addr, fetch_rdata;

    // register file read ports.
    addr_t   rs1_addr, rs2_addr;
    word_t   rs1_data, rs2_data;

    // execute to memory.
    logic    m_valid, m_ready, m_rd_en;
    mem_op_e m_op;
    addr_t   m_rd;
    word_t   m_result, m_store_data;

    // memory stage side of the bus.
    logic    mem_stage_req, mem_stage_we, load_valid;
    word_t   mem_stage_addr, mem_stage_wdata, load_rdata;

    // write port, shared by the register file and forwarding.
    logic    wb_en;
    addr_t   wb_addr;
    word_t   wb_data;

    fetch #(
        .RESET_ADDR(RESET_ADDR)
    ) u_fetch (.*);

    regfile u_regfile (.*);

    execute u_execute (.*);

    memory u_memory (.*);

    arbitrate u_arbitrate (.*);

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
// Core testbench
// Memory model, store checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    logic        clk;
    logic        rst_n;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    logic [31:0] mem [256];  // word array, byte address bits 9:2 select the word.
    logic [31:0] exp_addr [$];  // ordered expected stores.
    logic [31:0] exp_data [$];
    int          prog_words;
    int          store_count;
    int          value_errors;
    int          other_errors;
    int          cycle;
    bit          loaded;
    bit          first_seen;

    cpu #(
        .RESET_ADDR(32'h0)
    ) u_cpu (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    always #2 clk = ~clk;  // 4 ns period.

    // reads the program and the expected stores, skipping comment lines.
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("testbench/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file testbench/cpu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 2 && line.getc(0) != "#") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
                    if (n == 2 && line.getc(0) == "P") begin
                        mem[a[9:2]] = d;  // program or preset data word.
                        prog_words++;
                    end else if (n == 2 && line.getc(0) == "E") begin
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // bus monitor and memory model, both on the rising edge.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst_n && cycle > 0) begin
            assert (!mem_req && !mem_we) else begin
                other_errors++;
                $display("bus request seen while reset was held at time %0t", $time);
            end
        end
        if (rst_n && mem_req) begin
            if (!first_seen) begin
                first_seen <= 1'b1;
                assert (!mem_we && mem_addr == 32'h0) else begin
                    value_errors++;
                    $display("[ERROR] %0t first request addr %h we %b, expected a read of 0",
                             $time, mem_addr, mem_we);
                end
            end
            if (mem_we) begin
                if (store_count < exp_addr.size()) begin
                    assert (mem_addr == exp_addr[store_count] &&
                            mem_wdata == exp_data[store_count]) else begin
                        value_errors++;
                        $display("[ERROR] %0t store %0d wrote %h to %h, expected %h to %h",
                                 $time, store_count, mem_wdata, mem_addr,
                                 exp_data[store_count], exp_addr[store_count]);
                    end
                end else begin
                    assert (0) else begin
                        other_errors++;
                        $display("extra store of %h to %h after all expected stores",
                                 mem_wdata, mem_addr);
                    end
                end
                store_count <= store_count + 1;
                mem[mem_addr[9:2]] <= mem_wdata;  // write lands at the end of the cycle.
            end else begin
                assert (mem_addr[1:0] == 2'b00) else begin
                    value_errors++;
                    $display("[ERROR] %0t unaligned read address %h", $time, mem_addr);
                end
                mem_rdata <= mem[mem_addr[9:2]];  // data is valid in the next cycle.
            end
        end
    end

    // ends a run that never reaches its last store.
    initial begin
        int limit;
        wait (loaded);
        limit = prog_words * 20 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d of %0d stores seen",
                 limit, store_count, exp_addr.size());
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mem_rdata    = 32'h0;
        prog_words   = 0;
        store_count  = 0;
        value_errors = 0;
        other_errors = 0;
        cycle        = 0;
        first_seen   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i << 2) ^ 32'hc3a5_0f96;  // fill depends on the byte address.
        end
        load_stimulus();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (store_count >= exp_addr.size());
        repeat (40) @(posedge clk);  // leave room for stray stores to show up.
        assert (store_count == exp_addr.size()) else begin
            other_errors++;
            $display("saw %0d stores but expected %0d", store_count, exp_addr.size());
        end
        $display("errors: value %0d, other %0d, stores %0d of %0d",
                 value_errors, other_errors, store_count, exp_addr.size());
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/core.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/execute.sv
verilog/memory.sv
verilog/arbitrate.sv
verilog/cpu.sv
testbench/tb_cpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module tb_cpu -Mdir obj_dir
	out=$$(./obj_dir/Vtb_cpu); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

/* testbench/cpu_stimulus.txt */
# P <byte address> <program word>, all hex
# E <byte address> <expected store data>, in program order
P 00000000 123450b7
P 00000004 67808113
P 00000008 0ff14193
P 0000000c 00419213
P 00000010 00825293
P 00000014 40228333
P 00000018 005323b3
P 0000001c 00437433
P 00000020 007464b3
P 00000024 10000513
P 00000028 00252023
P 0000002c 00652223
P 00000030 00752423
P 00000034 00952623
P 00000038 00052583
P 0000003c 00958633
P 00000040 00c52823
P 00000044 00258463
P 00000048 00052a23
P 0000004c 00259463
P 00000050 00152a23
P 00000054 008006ef
P 00000058 00052c23
P 0000005c 00d52c23
P 00000060 0000006f
E 00000100 12345678
E 00000104 edeeeef0
E 00000108 00000001
E 0000010c 21446871
E 00000110 3378bee9
E 00000114 12345000
E 00000118 00000058
